// File: Makefile
# Verilator build and run for the DDR3 command sequencer testbench

VERILATOR ?= verilator
TOP       ?= ddr3_ctrl_tb
FILELIST  ?= ddr3_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SRCS := $(wildcard rtl/*.sv tb/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ddr3_ctrl.f
rtl/ddr3_ctrl_pkg.sv
rtl/ddr3_hold_slot.sv
rtl/ddr3_sequencer.sv
rtl/ddr3_cmd_encoder.sv
rtl/ddr3_burst_datapath.sv
rtl/ddr3_ctrl_top.sv
tb/tb_clock_gen.sv
tb/ddr3_ctrl_tb.sv

// File: rtl/ddr3_burst_datapath.sv
`timescale 1ns/100ps

module ddr3_burst_datapath (
    input  logic                       CLK,
    input  logic                       rst,
    input  logic                       load,
    input  ddr3_ctrl_pkg::burst_t      wr_burst,
    input  logic                       wr_beat,
    input  logic                       rd_beat,
    input  logic                       rd_last,
    output ddr3_ctrl_pkg::beat_t       dq_out,
    output logic                       dq_oe,
    input  ddr3_ctrl_pkg::beat_t       dq_in,
    output logic                       rsp_push,
    output ddr3_ctrl_pkg::read_rsp_t   rsp_data
);

    ddr3_ctrl_pkg::burst_t wr_shift;
    ddr3_ctrl_pkg::burst_t rd_shift;
    ddr3_ctrl_pkg::burst_t rd_next;
    logic                  rd_beat_q;
    logic                  rd_last_q;

    // Strobes delayed one cycle to meet the pins
    always_ff @(posedge CLK) begin
        if (rst) begin
            dq_oe     <= 1'b0;
            rd_beat_q <= 1'b0;
            rd_last_q <= 1'b0;
        end else begin
            dq_oe     <= wr_beat;
            rd_beat_q <= rd_beat;
            rd_last_q <= rd_last;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write side, low byte goes out first
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (load) begin
            wr_shift <= wr_burst;
        end else if (wr_beat) begin
            wr_shift <= wr_shift >> ddr3_ctrl_pkg::DQ_W;
        end
        if (wr_beat) dq_out <= wr_shift[ddr3_ctrl_pkg::DQ_W-1:0];
    end

    //////////////////////////////////////////////////////////////////////
    // Read side, new beat enters at the top
    //////////////////////////////////////////////////////////////////////
    // After eight beats, beat 0 has reached the low byte
    assign rd_next = {dq_in, rd_shift[ddr3_ctrl_pkg::BURST_LEN*ddr3_ctrl_pkg::DQ_W-1:
                                      ddr3_ctrl_pkg::DQ_W]};

    always_ff @(posedge CLK) begin
        if (rd_beat_q) rd_shift <= rd_next;
    end

    // Last beat goes straight into the response slot
    assign rsp_push         = rd_last_q;
    assign rsp_data.rd_data = rd_next;

endmodule

// File: rtl/ddr3_cmd_encoder.sv
`timescale 1ns/100ps

module ddr3_cmd_encoder (
    input  logic                              CLK,
    input  logic                              rst,
    input  ddr3_ctrl_pkg::dram_cmd_e          cmd,
    input  logic [ddr3_ctrl_pkg::BANK_W-1:0]  cmd_bank,
    input  logic [ddr3_ctrl_pkg::ROW_W-1:0]   cmd_row,
    input  logic [ddr3_ctrl_pkg::COL_W-1:0]   cmd_col,
    output ddr3_ctrl_pkg::dram_pins_t         pins
);

    ddr3_ctrl_pkg::dram_pins_t pins_d;

    // DDR3 truth table, strobes active low (cs ras cas we)
    always_comb begin
        pins_d      = ddr3_ctrl_pkg::PINS_DESELECT;
        pins_d.cs_n = 1'b0;
        case (cmd)
            ddr3_ctrl_pkg::DESELECT: pins_d = ddr3_ctrl_pkg::PINS_DESELECT;
            ddr3_ctrl_pkg::NOP: ;                         // 0 1 1 1
            ddr3_ctrl_pkg::ZQCL: begin                    // 0 1 1 0
                pins_d.we_n                        = 1'b0;
                pins_d.addr[ddr3_ctrl_pkg::AP_BIT] = 1'b1; // Long calibration
            end
            ddr3_ctrl_pkg::REFRESH: begin                 // 0 0 0 1
                pins_d.ras_n = 1'b0;
                pins_d.cas_n = 1'b0;
            end
            ddr3_ctrl_pkg::ACTIVATE: begin                // 0 0 1 1
                pins_d.ras_n = 1'b0;
                pins_d.addr  = cmd_row;
                pins_d.ba    = cmd_bank;
            end
            ddr3_ctrl_pkg::WRITE, ddr3_ctrl_pkg::READ: begin
                pins_d.cas_n = 1'b0;
                pins_d.we_n  = (cmd == ddr3_ctrl_pkg::READ);  // Low only for write
                // Column on the low bits, A10 low so no auto-precharge
                pins_d.addr  = ddr3_ctrl_pkg::ROW_W'(cmd_col);
                pins_d.ba    = cmd_bank;
            end
            ddr3_ctrl_pkg::PRECHARGE: begin               // 0 0 1 0
                pins_d.ras_n = 1'b0;
                pins_d.we_n  = 1'b0;
                pins_d.ba    = cmd_bank;                  // A10 low, one bank
            end
            default: pins_d = ddr3_ctrl_pkg::PINS_DESELECT;
        endcase
    end

    // Output register, one cycle behind the sequencer
    always_ff @(posedge CLK) begin
        if (rst) begin
            pins <= ddr3_ctrl_pkg::PINS_DESELECT;
        end else begin
            pins <= pins_d;
        end
    end

endmodule

// File: rtl/ddr3_ctrl_pkg.sv
package ddr3_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // DRAM timing, all in CLK cycles
    //////////////////////////////////////////////////////////////////////
    localparam int T_RESET   = 10;   // Reset pin held low
    localparam int T_ZQINIT  = 8;    // ZQCL to first usable cycle
    localparam int T_RFC     = 103;  // Refresh to next command
    localparam int T_RCD     = 10;   // Activate to column command
    localparam int RL        = 5;    // Read latency
    localparam int WL        = 7;    // Write latency
    localparam int BURST_LEN = 8;    // Beats per burst, BL8 only

    // Address and data widths
    localparam int ROW_W  = 15;
    localparam int COL_W  = 10;
    localparam int BANK_W = 3;
    localparam int DQ_W   = 8;

    localparam int AP_BIT = 10;      // A10, the long-calibration bit for ZQCL

    // Shared phase counter, sized for the longest wait (tRFC)
    localparam int CNT_W = $clog2(T_RFC);

    typedef logic [CNT_W-1:0]          cnt_t;
    typedef logic [DQ_W-1:0]           beat_t;
    typedef logic [BURST_LEN*DQ_W-1:0] burst_t;  // Beat 0 in the low byte

    // Commands the sequencer can issue
    typedef enum logic [2:0] {
        DESELECT,
        NOP,
        ZQCL,
        REFRESH,
        ACTIVATE,
        WRITE,
        READ,
        PRECHARGE
    } dram_cmd_e;

    //////////////////////////////////////////////////////////////////////
    // Request, response and pin bundles
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic              write;    // 1 = write, 0 = read
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
        burst_t            wr_data;  // Unused on reads
    } access_req_t;

    typedef struct packed {
        burst_t rd_data;
    } read_rsp_t;

    typedef struct packed {
        logic              cs_n;
        logic              ras_n;
        logic              cas_n;
        logic              we_n;
        logic [ROW_W-1:0]  addr;
        logic [BANK_W-1:0] ba;
    } dram_pins_t;

    // Chip not selected, all strobes high
    localparam dram_pins_t PINS_DESELECT = '{
        cs_n:  1'b1,
        ras_n: 1'b1,
        cas_n: 1'b1,
        we_n:  1'b1,
        addr:  '0,
        ba:    '0
    };

endpackage

// File: rtl/ddr3_ctrl_top.sv
`timescale 1ns/100ps

module ddr3_ctrl_top (
    input  logic                        CLK,
    input  logic                        rst,
    input  logic                        refresh_req,
    // Request slot
    input  logic                        req_valid,
    output logic                        req_ready,
    input  ddr3_ctrl_pkg::access_req_t  req,
    // Response slot
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output ddr3_ctrl_pkg::read_rsp_t    rsp,
    // DRAM side
    output logic                        dram_reset_n,
    output logic                        init_done,
    output ddr3_ctrl_pkg::dram_pins_t   pins,
    output ddr3_ctrl_pkg::beat_t        dq_out,
    output logic                        dq_oe,
    input  ddr3_ctrl_pkg::beat_t        dq_in
);

    ddr3_ctrl_pkg::access_req_t        req_held;
    logic                              req_held_valid;
    logic                              req_take;
    ddr3_ctrl_pkg::dram_cmd_e          cmd;
    logic [ddr3_ctrl_pkg::BANK_W-1:0]  cmd_bank;
    logic [ddr3_ctrl_pkg::ROW_W-1:0]   cmd_row;
    logic [ddr3_ctrl_pkg::COL_W-1:0]   cmd_col;
    logic                              load;
    logic                              wr_beat;
    logic                              rd_beat;
    logic                              rd_last;
    logic                              rsp_push;
    ddr3_ctrl_pkg::read_rsp_t          rsp_data;

    //////////////////////////////////////////////////////////////////////
    // Request and response slots
    //////////////////////////////////////////////////////////////////////
    ddr3_hold_slot #(.payload_t(ddr3_ctrl_pkg::access_req_t)) u_req_slot (
        .CLK       (CLK),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (req_held_valid),
        .out_take  (req_take),
        .out_data  (req_held)
    );

    // Never pushed while full, the sequencer waits for it to drain
    ddr3_hold_slot #(.payload_t(ddr3_ctrl_pkg::read_rsp_t)) u_rsp_slot (
        .CLK       (CLK),
        .rst       (rst),
        .in_valid  (rsp_push),
        .in_ready  (),
        .in_data   (rsp_data),
        .out_valid (rsp_valid),
        .out_take  (rsp_ready),
        .out_data  (rsp)
    );

    ddr3_sequencer u_sequencer (
        .CLK          (CLK),
        .rst          (rst),
        .refresh_req  (refresh_req),
        .req_valid    (req_held_valid),
        .req          (req_held),
        .req_take     (req_take),
        .rsp_busy     (rsp_valid),      // Full response slot blocks Activate
        .cmd          (cmd),
        .cmd_bank     (cmd_bank),
        .cmd_row      (cmd_row),
        .cmd_col      (cmd_col),
        .dram_reset_n (dram_reset_n),
        .init_done    (init_done),
        .load         (load),
        .wr_beat      (wr_beat),
        .rd_beat      (rd_beat),
        .rd_last      (rd_last)
    );

    ddr3_cmd_encoder u_cmd_encoder (
        .CLK      (CLK),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_bank (cmd_bank),
        .cmd_row  (cmd_row),
        .cmd_col  (cmd_col),
        .pins     (pins)
    );

    ddr3_burst_datapath u_burst_datapath (
        .CLK      (CLK),
        .rst      (rst),
        .load     (load),
        .wr_burst (req_held.wr_data),   // Sampled on the take cycle
        .wr_beat  (wr_beat),
        .rd_beat  (rd_beat),
        .rd_last  (rd_last),
        .dq_out   (dq_out),
        .dq_oe    (dq_oe),
        .dq_in    (dq_in),
        .rsp_push (rsp_push),
        .rsp_data (rsp_data)
    );

endmodule

// File: rtl/ddr3_hold_slot.sv
`timescale 1ns/100ps

module ddr3_hold_slot #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_take,
    output payload_t out_data
);

    logic full;
    logic fill;

    assign fill      = in_valid && !full;  // Only accepts when empty
    assign in_ready  = !full;
    assign out_valid = full;

    always_ff @(posedge CLK) begin
        if (rst) begin
            full <= 1'b0;
        end else if (fill) begin
            full <= 1'b1;
        end else if (out_take) begin
            full <= 1'b0;                  // Consumer popped the entry
        end
    end

    // Payload held until the next fill
    always_ff @(posedge CLK) begin
        if (fill) begin
            out_data <= in_data;
        end
    end

endmodule

// File: rtl/ddr3_sequencer.sv
`timescale 1ns/100ps

module ddr3_sequencer (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic                              refresh_req,
    input  logic                              req_valid,
    input  ddr3_ctrl_pkg::access_req_t        req,
    output logic                              req_take,
    input  logic                              rsp_busy,
    output ddr3_ctrl_pkg::dram_cmd_e          cmd,
    output logic [ddr3_ctrl_pkg::BANK_W-1:0]  cmd_bank,
    output logic [ddr3_ctrl_pkg::ROW_W-1:0]   cmd_row,
    output logic [ddr3_ctrl_pkg::COL_W-1:0]   cmd_col,
    output logic                              dram_reset_n,
    output logic                              init_done,
    output logic                              load,
    output logic                              wr_beat,
    output logic                              rd_beat,
    output logic                              rd_last
);

    typedef enum logic [3:0] {
        S_RESET,    // DRAM reset pin low
        S_ZQ,       // Issue ZQCL
        S_ZQ_WAIT,
        S_IDLE,
        S_REF,      // Issue REFRESH
        S_RFC,      // tRFC wait
        S_ACT,      // Issue ACTIVATE
        S_RCD,      // tRCD wait
        S_COL,      // Issue WRITE or READ
        S_LAT,      // WL or RL wait
        S_BURST,    // One beat per cycle
        S_PRE       // Close the bank
    } state_e;

    state_e                    state, state_n;
    ddr3_ctrl_pkg::cnt_t       cnt;
    ddr3_ctrl_pkg::cnt_t       cnt_val;
    logic                      cnt_load;
    logic                      is_write;
    logic                      cnt_zero;

    assign cnt_zero = (cnt == '0);

    //////////////////////////////////////////////////////////////////////
    // Next state, command and beat strobes
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_n  = state;
        cnt_load = 1'b0;
        cnt_val  = '0;
        cmd      = ddr3_ctrl_pkg::NOP;
        req_take = 1'b0;
        load     = 1'b0;
        wr_beat  = 1'b0;
        rd_beat  = 1'b0;
        rd_last  = 1'b0;
        case (state)
            S_RESET: begin
                cmd = ddr3_ctrl_pkg::DESELECT;  // cs_n high through the hold
                if (cnt_zero) state_n = S_ZQ;
            end
            S_ZQ: begin
                cmd      = ddr3_ctrl_pkg::ZQCL;
                state_n  = S_ZQ_WAIT;
                cnt_load = 1'b1;
                cnt_val  = ddr3_ctrl_pkg::cnt_t'(ddr3_ctrl_pkg::T_ZQINIT - 1);
            end
            S_ZQ_WAIT: begin
                if (cnt_zero) state_n = S_IDLE;
            end
            S_IDLE: begin
                if (refresh_req) begin          // Refresh wins over requests
                    state_n = S_REF;
                end else if (req_valid && !rsp_busy) begin
                    req_take = 1'b1;
                    load     = req.write;       // Burst into the write shifter
                    state_n  = S_ACT;
                end
            end
            S_REF: begin
                cmd      = ddr3_ctrl_pkg::REFRESH;
                state_n  = S_RFC;
                cnt_load = 1'b1;
                cnt_val  = ddr3_ctrl_pkg::cnt_t'(ddr3_ctrl_pkg::T_RFC - 1);
            end
            S_RFC: begin
                // Back to back refresh while the request stays up
                if (cnt_zero) state_n = refresh_req ? S_REF : S_IDLE;
            end
            S_ACT: begin
                cmd      = ddr3_ctrl_pkg::ACTIVATE;
                state_n  = S_RCD;
                cnt_load = 1'b1;
                cnt_val  = ddr3_ctrl_pkg::cnt_t'(ddr3_ctrl_pkg::T_RCD - 2);
            end
            S_RCD: begin
                if (cnt_zero) state_n = S_COL;
            end
            S_COL: begin
                cmd      = is_write ? ddr3_ctrl_pkg::WRITE : ddr3_ctrl_pkg::READ;
                state_n  = S_LAT;
                cnt_load = 1'b1;
                // Latency minus this cycle minus the beat strobe register
                cnt_val  = is_write ? ddr3_ctrl_pkg::cnt_t'(ddr3_ctrl_pkg::WL - 2)
                                    : ddr3_ctrl_pkg::cnt_t'(ddr3_ctrl_pkg::RL - 2);
            end
            S_LAT: begin
                if (cnt_zero) begin
                    state_n  = S_BURST;
                    cnt_load = 1'b1;
                    cnt_val  = ddr3_ctrl_pkg::cnt_t'(ddr3_ctrl_pkg::BURST_LEN - 1);
                end
            end
            S_BURST: begin
                wr_beat = is_write;
                rd_beat = !is_write;
                rd_last = !is_write && cnt_zero;
                if (cnt_zero) state_n = S_PRE;
            end
            S_PRE: begin
                cmd     = ddr3_ctrl_pkg::PRECHARGE;  // Same bank as the access
                state_n = S_IDLE;
            end
            default: state_n = S_RESET;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State, shared down-counter, reset pin and init flag
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (rst) begin
            state        <= S_RESET;
            cnt          <= ddr3_ctrl_pkg::cnt_t'(ddr3_ctrl_pkg::T_RESET - 1);
            dram_reset_n <= 1'b0;
            init_done    <= 1'b0;
        end else begin
            state <= state_n;
            if (cnt_load) begin
                cnt <= cnt_val;
            end else if (!cnt_zero) begin
                cnt <= cnt - 1'b1;
            end
            // Registered so both line up with the encoder pins
            if (state == S_RESET && cnt_zero) dram_reset_n <= 1'b1;
            if (state == S_ZQ_WAIT && cnt_zero) init_done <= 1'b1;
        end
    end

    // Fields of the taken request, held until the next take
    always_ff @(posedge CLK) begin
        if (req_take) begin
            is_write <= req.write;
            cmd_bank <= req.bank;
            cmd_row  <= req.row;
            cmd_col  <= req.col;
        end
    end

endmodule

// File: tb/ddr3_ctrl_tb.sv
`timescale 1ns/100ps

module ddr3_ctrl_tb;

    localparam int TIMEOUT_CYCLES = 2000;  // Reset, two refreshes, four accesses with margin
    localparam int NUM_REQ        = 4;

    logic                       CLK, rst, refresh_req, req_valid, req_ready;
    logic                       rsp_valid, rsp_ready, dram_reset_n, init_done, dq_oe;
    ddr3_ctrl_pkg::access_req_t req;
    ddr3_ctrl_pkg::read_rsp_t   rsp, rsp_q;
    ddr3_ctrl_pkg::dram_pins_t  pins;
    ddr3_ctrl_pkg::beat_t       dq_out;
    ddr3_ctrl_pkg::beat_t       dq_in = '0;            // Driven by the pin model
    ddr3_ctrl_pkg::access_req_t reqs [NUM_REQ];
    ddr3_ctrl_pkg::access_req_t cur = '0;              // Access now open in the DRAM
    int cyc = 0, mismatch_count = 0, fault_count = 0;
    int n_act = 0, n_pre = 0, n_rsp = 0, n_refresh = 0, n_wbeats = 0, beats = 0;
    int low_cnt = 0, rise_cyc = -1, zq_cyc = -1, act_cyc = 0, col_cyc = 0, rd_cyc = 0;
    int lat = 0, nop_run = 0;
    logic ref_open = 1'b0, rd_open = 1'b0, reset_n_q = 1'b0, init_q = 1'b0;
    logic rsp_valid_q = 1'b0, held_q = 1'b0;
    logic [1:0] ref_hist = '0;                         // refresh_req one and two cycles back
    logic [ddr3_ctrl_pkg::COL_W-1:0] rd_col = '0;

    tb_clock_gen u_clock_gen (.CLK(CLK), .rst(rst));

    ddr3_ctrl_top u_dut (.CLK(CLK), .rst(rst), .refresh_req(refresh_req),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
        .dram_reset_n(dram_reset_n), .init_done(init_done), .pins(pins),
        .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in));

    // DDR3 truth table on {ras_n, cas_n, we_n} with cs_n low
    function automatic ddr3_ctrl_pkg::dram_cmd_e decode_cmd(input ddr3_ctrl_pkg::dram_pins_t p);
        if (p.cs_n) return ddr3_ctrl_pkg::DESELECT;
        case ({p.ras_n, p.cas_n, p.we_n})
            3'b111:  return ddr3_ctrl_pkg::NOP;
            3'b110:  return ddr3_ctrl_pkg::ZQCL;
            3'b001:  return ddr3_ctrl_pkg::REFRESH;
            3'b011:  return ddr3_ctrl_pkg::ACTIVATE;
            3'b100:  return ddr3_ctrl_pkg::WRITE;
            3'b101:  return ddr3_ctrl_pkg::READ;
            3'b010:  return ddr3_ctrl_pkg::PRECHARGE;
            default: return ddr3_ctrl_pkg::DESELECT;
        endcase
    endfunction

    // DRAM read data depends on column and beat only
    function automatic ddr3_ctrl_pkg::beat_t read_byte(input logic [ddr3_ctrl_pkg::COL_W-1:0] col,
                                                       input int k);
        return col[7:0] ^ 8'(k * 37) ^ 8'hA5;
    endfunction

    task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
        mismatch_count++;
        $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
    endtask

    task automatic fault(input string msg);
        fault_count++;
        $display("%s", msg);
    endtask

    // Request goes in on the falling edge once the slot has room
    task automatic push_req(input ddr3_ctrl_pkg::access_req_t r);
        @(negedge CLK);
        while (!req_ready) @(negedge CLK);
        req_valid = 1'b1;
        req       = r;
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    cs_high_in_reset: assert property (@(posedge CLK) disable iff (rst)
        !dram_reset_n |-> pins.cs_n)
        else fault("cs_n went low while the DRAM reset pin was held");

    always @(posedge CLK) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cyc);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Pin model drives dq_in on the falling edge, RL cycles after READ
    always @(negedge CLK) begin
        int k;
        k = cyc - rd_cyc - ddr3_ctrl_pkg::RL;
        if (rd_open && k >= 0 && k < ddr3_ctrl_pkg::BURST_LEN) begin
            dq_in <= read_byte(rd_col, k);
        end else begin
            dq_in <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Pin monitor and checks sampled on the rising edge
    ////////////////////////////////////////////////////////////////////////
    always @(posedge CLK) begin
        ddr3_ctrl_pkg::dram_cmd_e c;
        int k;
        ddr3_ctrl_pkg::burst_t exp_burst;
        c = decode_cmd(pins);
        if (!rst) begin
            if (!dram_reset_n) low_cnt++;
            if (dram_reset_n && !reset_n_q) begin
                rise_cyc = cyc;
                assert (low_cnt == ddr3_ctrl_pkg::T_RESET)
                    else mismatch("reset_hold", 64'(ddr3_ctrl_pkg::T_RESET), 64'(low_cnt));
            end
            if (c == ddr3_ctrl_pkg::ZQCL) begin
                zq_cyc = cyc;
                assert (cyc == rise_cyc + 1)
                    else mismatch("zqcl_cycle", 64'(rise_cyc + 1), 64'(cyc));
                assert (pins.addr[10]) else fault("ZQCL issued without A10 set");
            end
            if (init_done && !init_q) begin
                assert (cyc == zq_cyc + ddr3_ctrl_pkg::T_ZQINIT)
                    else mismatch("init_done_cycle",
                                  64'(zq_cyc + ddr3_ctrl_pkg::T_ZQINIT), 64'(cyc));
            end
            // tRFC gap counted in NOP cycles
            if (ref_open && c != ddr3_ctrl_pkg::NOP) begin
                ref_open = 1'b0;
                assert (c == ddr3_ctrl_pkg::REFRESH ? nop_run == ddr3_ctrl_pkg::T_RFC
                                                    : nop_run >= ddr3_ctrl_pkg::T_RFC)
                    else mismatch("rfc_gap", 64'(ddr3_ctrl_pkg::T_RFC), 64'(nop_run));
            end else if (ref_open) begin
                nop_run++;
            end
            if (c == ddr3_ctrl_pkg::REFRESH) begin
                n_refresh++;
                ref_open = 1'b1;
                nop_run  = 0;
            end
            if (c == ddr3_ctrl_pkg::ACTIVATE) begin
                if (n_act < NUM_REQ) cur = reqs[n_act];
                n_act++;
                act_cyc = cyc;
                beats   = 0;
                assert (!ref_hist[1]) else fault("ACTIVATE issued although refresh was requested");
                assert (!rsp_valid) else fault("ACTIVATE issued while a response was waiting");
                assert (pins.ba == cur.bank && pins.addr == cur.row)
                    else mismatch("activate_addr", 64'({cur.bank, cur.row}),
                                  64'({pins.ba, pins.addr}));
            end
            if (c == ddr3_ctrl_pkg::WRITE || c == ddr3_ctrl_pkg::READ) begin
                col_cyc = cyc;
                lat     = (c == ddr3_ctrl_pkg::WRITE) ? ddr3_ctrl_pkg::WL : ddr3_ctrl_pkg::RL;
                assert (cyc == act_cyc + ddr3_ctrl_pkg::T_RCD)
                    else mismatch("rcd_gap", 64'(ddr3_ctrl_pkg::T_RCD), 64'(cyc - act_cyc));
                assert ((c == ddr3_ctrl_pkg::WRITE) == cur.write)
                    else fault("Column command direction differs from the request");
                assert (pins.ba == cur.bank && pins.addr == ddr3_ctrl_pkg::ROW_W'(cur.col))
                    else mismatch("column_addr",
                                  64'({cur.bank, ddr3_ctrl_pkg::ROW_W'(cur.col)}),
                                  64'({pins.ba, pins.addr}));
                if (c == ddr3_ctrl_pkg::READ) begin
                    rd_open = 1'b1;
                    rd_cyc  = cyc;
                    rd_col  = pins.addr[ddr3_ctrl_pkg::COL_W-1:0];
                end
            end
            if (dq_oe) begin
                k = cyc - col_cyc - ddr3_ctrl_pkg::WL;
                beats++;
                n_wbeats++;
                assert (cur.write && k >= 0 && k < ddr3_ctrl_pkg::BURST_LEN)
                    else fault("dq_oe high outside a write burst");
                if (k >= 0 && k < ddr3_ctrl_pkg::BURST_LEN) begin
                    assert (dq_out == cur.wr_data[k*8 +: 8])
                        else mismatch("write_beat", 64'(cur.wr_data[k*8 +: 8]), 64'(dq_out));
                end
            end
            if (c == ddr3_ctrl_pkg::PRECHARGE) begin
                n_pre++;
                rd_open = 1'b0;
                assert (cyc == col_cyc + lat + ddr3_ctrl_pkg::BURST_LEN)
                    else mismatch("precharge_cycle",
                                  64'(col_cyc + lat + ddr3_ctrl_pkg::BURST_LEN), 64'(cyc));
                assert (pins.ba == cur.bank)
                    else mismatch("precharge_bank", 64'(cur.bank), 64'(pins.ba));
                if (cur.write) begin
                    assert (beats == ddr3_ctrl_pkg::BURST_LEN)
                        else mismatch("write_beat_count",
                                      64'(ddr3_ctrl_pkg::BURST_LEN), 64'(beats));
                end
            end
            // Read response timing, hold under back-pressure and data
            if (rsp_valid && !rsp_valid_q) begin
                assert (cyc == rd_cyc + ddr3_ctrl_pkg::RL + ddr3_ctrl_pkg::BURST_LEN)
                    else mismatch("rsp_valid_cycle",
                                  64'(rd_cyc + ddr3_ctrl_pkg::RL + ddr3_ctrl_pkg::BURST_LEN),
                                  64'(cyc));
            end
            if (held_q) begin
                assert (rsp_valid) else fault("rsp_valid dropped while rsp_ready was low");
                assert (rsp == rsp_q) else mismatch("rsp_stable", rsp_q.rd_data, rsp.rd_data);
            end
            if (rsp_valid && rsp_ready) begin
                for (k = 0; k < ddr3_ctrl_pkg::BURST_LEN; k++) begin
                    exp_burst[k*8 +: 8] = read_byte(cur.col, k);
                end
                n_rsp++;
                assert (rsp.rd_data == exp_burst)
                    else mismatch("read_data", exp_burst, rsp.rd_data);
            end
        end
        reset_n_q   = dram_reset_n;
        init_q      = init_done;
        rsp_valid_q = rsp_valid;
        held_q      = rsp_valid && !rsp_ready;
        rsp_q       = rsp;
        ref_hist    = {ref_hist[0], refresh_req};
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus for reset, refresh with a pending write, read and back-pressure
    ////////////////////////////////////////////////////////////////////////
    initial begin
        int seed, total;
        seed        = 5;
        refresh_req = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        rsp_ready   = 1'b1;
        for (int i = 0; i < NUM_REQ; i++) begin
            reqs[i].bank    = 3'($random(seed));
            reqs[i].row     = 15'($random(seed));
            reqs[i].col     = 10'($random(seed));
            reqs[i].wr_data = {32'($random(seed)), 32'($random(seed))};
        end
        reqs[0].write = 1'b1;  // Write, read, read under back-pressure, queued write
        reqs[1].write = 1'b0;
        reqs[2].write = 1'b0;
        reqs[3].write = 1'b1;
        while (rst !== 1'b0) @(negedge CLK);
        @(negedge CLK);
        assert (req_ready && !dq_oe && !rsp_valid && !init_done && pins.cs_n)
            else fault("Outputs not in their idle state after reset");
        while (!init_done) @(negedge CLK);
        refresh_req = 1'b1;               // Write waits behind two refreshes
        push_req(reqs[0]);
        while (n_refresh < 2) @(negedge CLK);
        refresh_req = 1'b0;
        while (n_pre < 1) @(negedge CLK);
        push_req(reqs[1]);
        while (n_rsp < 1) @(negedge CLK);
        rsp_ready = 1'b0;
        push_req(reqs[2]);
        while (!rsp_valid) @(negedge CLK);
        push_req(reqs[3]);                // Held back until the response drains
        repeat (20) @(negedge CLK);
        rsp_ready = 1'b1;
        while (n_pre < NUM_REQ) @(negedge CLK);
        repeat (4) @(negedge CLK);
        if (n_act != NUM_REQ) mismatch("activate_count", 64'(NUM_REQ), 64'(n_act));
        if (n_rsp != 2) mismatch("response_count", 64'(2), 64'(n_rsp));
        if (n_refresh != 2) mismatch("refresh_count", 64'(2), 64'(n_refresh));
        if (n_wbeats != 2 * ddr3_ctrl_pkg::BURST_LEN) begin
            mismatch("write_beats", 64'(2 * ddr3_ctrl_pkg::BURST_LEN), 64'(n_wbeats));
        end
        if (zq_cyc < 0) fault("No ZQCL command seen");
        total = mismatch_count + fault_count;
        $display("Errors: %0d value mismatches, %0d other failures, %0d total",
                 mismatch_count, fault_count, total);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic CLK,
    output logic rst
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2.0) CLK = ~CLK;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
    end

endmodule
